//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int ADDR_W    = 32;
	localparam int DATA_W    = 32;

	// RAM is word addressed through addr[9:2]
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = $clog2(RAM_WORDS);
	localparam int RAM_WAIT  = 2;		// Cycles from request to ready
	localparam int WAIT_W    = $clog2(RAM_WAIT + 1);

	localparam int NUM_PORTS  = 3;
	localparam int PORT_FETCH = 0;
	localparam int PORT_DATA  = 1;
	localparam int PORT_AUX   = 2;

	typedef logic [NUM_PORTS-1:0] port_sel_t;	// One-hot

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
	} fetch_req_t;

	typedef struct packed {
		logic              rw;		// 1 = write
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic              req;
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_cmd_t;

	typedef struct packed {
		logic              ready;	// Single-cycle pulse
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

//--- bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module bus_port
	import bus_pkg::*;
#(
	parameter type req_t = mem_req_t
)(
	input  wire logic              i_clock,
	input  wire logic              i_reset,
	input  wire logic              i_req,
	input  wire req_t              i_payload,
	input  wire logic              i_done,
	input  wire bus_rsp_t          i_rsp,
	output      logic              o_ack,
	output      logic [DATA_W-1:0] o_rdata,
	output      logic              o_pending,
	output      req_t              o_payload
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PENDING,
		ST_ACKING,
		ST_RELEASING
	} port_state_t;

	port_state_t state;
	req_t        payload_q;
	logic [DATA_W-1:0] rdata_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (i_req)
						state <= ST_PENDING;
				end
				ST_PENDING: begin
					if (i_done)
						state <= ST_ACKING;
				end
				ST_ACKING: begin
					if (!i_req)
						state <= ST_RELEASING;	// Master has let go
				end
				ST_RELEASING: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE && i_req)
			payload_q <= i_payload;		// Master bus is free after this
		if (state == ST_PENDING && i_done)
			rdata_q <= i_rsp.rdata;
	end

	assign o_pending = (state == ST_PENDING);
	assign o_ack     = (state == ST_ACKING);
	assign o_payload = payload_q;
	assign o_rdata   = rdata_q;

	// Ack only follows a completed bus transaction
	a_ack_after_done: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_ack) |-> $past(i_done));

endmodule

`default_nettype wire

//--- bus_arbiter_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter_ctrl
	import bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_reset,
	input  wire port_sel_t i_pending,
	input  wire bus_rsp_t  i_rsp,
	output      port_sel_t o_grant,
	output      logic      o_load,
	output      port_sel_t o_done
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} arb_state_t;

	arb_state_t state;
	port_sel_t  pick;
	port_sel_t  grant_q;

	// Fixed priority with data first and aux last
	always_comb begin
		pick = '0;
		if (i_pending[PORT_DATA])
			pick[PORT_DATA] = 1'b1;
		else if (i_pending[PORT_FETCH])
			pick[PORT_FETCH] = 1'b1;
		else if (i_pending[PORT_AUX])
			pick[PORT_AUX] = 1'b1;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state   <= ST_IDLE;
			grant_q <= '0;
		end
		else begin
			case (state)
				ST_IDLE: begin
					if (|i_pending) begin
						grant_q <= pick;
						state   <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					// Wait until the slave answers
					if (i_rsp.ready) begin
						grant_q <= '0;
						state   <= ST_IDLE;
					end
				end
				default: begin
					grant_q <= '0;
					state   <= ST_IDLE;
				end
			endcase
		end
	end

	// Grant is live in the idle cycle so the mux can load from it
	always_comb begin
		o_grant = grant_q;
		o_load  = 1'b0;
		o_done  = '0;
		case (state)
			ST_IDLE: begin
				o_grant = pick;
				o_load  = |i_pending;
			end
			ST_BUSY: begin
				if (i_rsp.ready)
					o_done = grant_q;
			end
			default: ;
		endcase
	end

	a_grant_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(o_grant));

	// Done only goes to the port that owns the bus
	a_done_in_grant: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_done & ~o_grant) == '0);

endmodule

`default_nettype wire

//--- bus_command_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bus_command_mux
	import bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_reset,
	input  wire port_sel_t i_grant,
	input  wire logic      i_load,
	input  wire mem_req_t  i_fetch,
	input  wire mem_req_t  i_data,
	input  wire mem_req_t  i_aux,
	input  wire bus_rsp_t  i_rsp,
	output      bus_cmd_t  o_cmd
);

	mem_req_t sel;

	always_comb begin
		sel = i_aux;
		if (i_grant[PORT_DATA])
			sel = i_data;
		else if (i_grant[PORT_FETCH]) begin
			sel    = i_fetch;
			sel.rw = 1'b0;		// Fetch is read only
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_cmd.req <= 1'b0;
		end
		else if (i_load) begin
			o_cmd.req <= 1'b1;
		end
		else if (i_rsp.ready) begin
			o_cmd.req <= 1'b0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_load) begin
			o_cmd.rw    <= sel.rw;
			o_cmd.addr  <= sel.addr;
			o_cmd.wdata <= sel.wdata;
		end
	end

	a_cmd_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_cmd.req && $past(o_cmd.req))
			|-> $stable({o_cmd.rw, o_cmd.addr, o_cmd.wdata}));

endmodule

`default_nettype wire

//--- bus_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ram
	import bus_pkg::*;
(
	input  wire logic     i_clock,
	input  wire logic     i_reset,
	input  wire bus_cmd_t i_cmd,
	output      bus_rsp_t o_rsp
);

	logic [DATA_W-1:0] mem [RAM_WORDS];
	logic [WAIT_W-1:0] wait_cnt;
	logic              ready_q;
	logic [DATA_W-1:0] rdata_q;
	logic [RAM_AW-1:0] word;

	assign word = i_cmd.addr[RAM_AW+1:2];	// Upper bits alias

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_cnt <= '0;
			ready_q  <= 1'b0;
		end
		else if (ready_q) begin
			wait_cnt <= '0;
			ready_q  <= 1'b0;
		end
		else if (i_cmd.req) begin
			if (wait_cnt == WAIT_W'(RAM_WAIT - 1))
				ready_q <= 1'b1;
			else
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// Read data lines up with ready
	always_ff @(posedge i_clock) begin
		if (i_cmd.req && !ready_q && wait_cnt == WAIT_W'(RAM_WAIT - 1))
			rdata_q <= mem[word];
	end

	// Write lands at the end of the ready cycle
	always_ff @(posedge i_clock) begin
		if (ready_q && i_cmd.req && i_cmd.rw)
			mem[word] <= i_cmd.wdata;
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

	a_req_held: assert property (@(posedge i_clock) disable iff (i_reset)
		$fell(i_cmd.req) |-> $past(o_rsp.ready));

endmodule

`default_nettype wire

//--- bus_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_access_top
	import bus_pkg::*;
(
	input  wire logic              i_clock,
	input  wire logic              i_reset,

	input  wire logic              i_fetch_req,
	input  wire fetch_req_t        i_fetch,
	output      logic              o_fetch_ack,
	output      logic [DATA_W-1:0] o_fetch_rdata,

	input  wire logic              i_data_req,
	input  wire mem_req_t          i_data,
	output      logic              o_data_ack,
	output      logic [DATA_W-1:0] o_data_rdata,

	input  wire logic              i_aux_req,
	input  wire mem_req_t          i_aux,
	output      logic              o_aux_ack,
	output      logic [DATA_W-1:0] o_aux_rdata
);

	port_sel_t  pending;
	port_sel_t  grant;
	port_sel_t  done;
	logic       load;
	fetch_req_t fetch_q;
	mem_req_t   fetch_wide;
	mem_req_t   data_q;
	mem_req_t   aux_q;
	bus_cmd_t   cmd;
	bus_rsp_t   rsp;

	bus_port #(.req_t(fetch_req_t)) u_fetch_port (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_req     (i_fetch_req),
		.i_payload (i_fetch),
		.i_done    (done[PORT_FETCH]),
		.i_rsp     (rsp),
		.o_ack     (o_fetch_ack),
		.o_rdata   (o_fetch_rdata),
		.o_pending (pending[PORT_FETCH]),
		.o_payload (fetch_q)
	);

	// Fetch becomes a plain read
	assign fetch_wide = '{rw: 1'b0, addr: fetch_q.addr, wdata: '0};

	bus_port #(.req_t(mem_req_t)) u_data_port (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_req     (i_data_req),
		.i_payload (i_data),
		.i_done    (done[PORT_DATA]),
		.i_rsp     (rsp),
		.o_ack     (o_data_ack),
		.o_rdata   (o_data_rdata),
		.o_pending (pending[PORT_DATA]),
		.o_payload (data_q)
	);

	bus_port #(.req_t(mem_req_t)) u_aux_port (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_req     (i_aux_req),
		.i_payload (i_aux),
		.i_done    (done[PORT_AUX]),
		.i_rsp     (rsp),
		.o_ack     (o_aux_ack),
		.o_rdata   (o_aux_rdata),
		.o_pending (pending[PORT_AUX]),
		.o_payload (aux_q)
	);

	bus_arbiter_ctrl u_arbiter (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_pending (pending),
		.i_rsp     (rsp),
		.o_grant   (grant),
		.o_load    (load),
		.o_done    (done)
	);

	bus_command_mux u_cmd_mux (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_grant (grant),
		.i_load  (load),
		.i_fetch (fetch_wide),
		.i_data  (data_q),
		.i_aux   (aux_q),
		.i_rsp   (rsp),
		.o_cmd   (cmd)
	);

	bus_ram u_ram (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_cmd   (cmd),
		.o_rsp   (rsp)
	);

endmodule

`default_nettype wire

//--- tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// RAM word from bits 9 down to 2 of a byte address
function automatic int word_of(input logic [ADDR_W-1:0] addr);
	return int'(addr[9:2]);
endfunction

function automatic string port_name(input int port);
	case (port)
		PORT_FETCH: return "fetch";
		PORT_DATA:  return "data";
		default:    return "aux";
	endcase
endfunction

function automatic logic port_ack(input int port);
	case (port)
		PORT_FETCH: return fetch_ack;
		PORT_DATA:  return data_ack;
		default:    return aux_ack;
	endcase
endfunction

function automatic logic [DATA_W-1:0] port_rdata(input int port);
	case (port)
		PORT_FETCH: return fetch_rdata;
		PORT_DATA:  return data_rdata;
		default:    return aux_rdata;
	endcase
endfunction

task automatic check_value(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
	if (got !== exp) begin
		errors++;
		$display("ERROR: %s is %h, expected %h", name, got, exp);
	end
endtask

task automatic begin_test();
	test_start_errors = errors;
endtask

task automatic end_test(input string name);
	if (errors == test_start_errors) begin
		pass_count++;
		$display("%s: passed", name);
	end
	else begin
		fail_count++;
		$display("%s: failed with %0d errors", name, errors - test_start_errors);
	end
endtask

// Drives one port's req and payload on a falling edge
task automatic raise_req(input int port, input logic rw, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata);
	@(negedge clock);
	case (port)
		PORT_FETCH: begin
			fetch.addr = addr;
			fetch_req  = 1'b1;
		end
		PORT_DATA: begin
			data     = '{rw: rw, addr: addr, wdata: wdata};
			data_req = 1'b1;
		end
		default: begin
			aux     = '{rw: rw, addr: addr, wdata: wdata};
			aux_req = 1'b1;
		end
	endcase
endtask

task automatic drop_req(input int port);
	@(negedge clock);
	case (port)
		PORT_FETCH: fetch_req = 1'b0;
		PORT_DATA:  data_req  = 1'b0;
		default:    aux_req   = 1'b0;
	endcase
endtask

task automatic wait_ack(input int port);
	int n;
	n = 0;
	while (!port_ack(port) && n < ACK_POLL) begin
		@(negedge clock);
		n++;
	end
	if (port_ack(port)) begin
		ack_seq[port] = seq_next;	// Order in which acks arrived
		seq_next++;
	end
	else begin
		errors++;
		$display("%s port: ack never arrived within %0d cycles", port_name(port), ACK_POLL);
	end
endtask

task automatic wait_ack_low(input int port);
	int n;
	n = 0;
	while (port_ack(port) && n < ACK_POLL) begin
		@(negedge clock);
		n++;
	end
	if (port_ack(port)) begin
		errors++;
		$display("%s port: ack stayed high after req was dropped", port_name(port));
	end
endtask

// Full four-phase sequence that mirrors writes in the scoreboard
task automatic master_access(input int port, input logic rw, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
	raise_req(port, rw, addr, wdata);
	wait_ack(port);
	rdata = port_rdata(port);
	if (rw)
		sb[word_of(addr)] = wdata;
	drop_req(port);
	wait_ack_low(port);
endtask

task automatic do_write(input int port, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] wdata);
	logic [DATA_W-1:0] unused;
	master_access(port, 1'b1, addr, wdata, unused);
endtask

task automatic read_check(input int port, input logic [ADDR_W-1:0] addr);
	logic [DATA_W-1:0] rd;
	master_access(port, 1'b0, addr, '0, rd);
	check_value({"o_", port_name(port), "_rdata"}, rd, sb[word_of(addr)]);
endtask

task automatic test_reset_state();
	begin_test();
	check_value("o_fetch_ack", fetch_ack, 1'b0);
	check_value("o_data_ack", data_ack, 1'b0);
	check_value("o_aux_ack", aux_ack, 1'b0);
	check_value("bus cmd.req", dut0.cmd.req, 1'b0);
	check_value("bus rsp.ready", dut0.rsp.ready, 1'b0);
	end_test("reset_state");
endtask

task automatic test_data_aux_rw();
	begin_test();
	do_write(PORT_DATA, 32'h0000_0040, $urandom);
	read_check(PORT_DATA, 32'h0000_0040);
	do_write(PORT_AUX, 32'h0000_0044, $urandom);
	read_check(PORT_AUX, 32'h0000_0044);
	end_test("data_aux_rw");
endtask

task automatic test_fetch_shared();
	begin_test();
	do_write(PORT_DATA, 32'h0000_0080, $urandom);
	read_check(PORT_FETCH, 32'h0000_0080);
	end_test("fetch_shared");
endtask

task automatic test_priority();
	logic [DATA_W-1:0] val_a;
	logic [DATA_W-1:0] val_c;
	logic [DATA_W-1:0] rd_data;
	logic [DATA_W-1:0] rd_fetch;
	logic [DATA_W-1:0] rd_aux;
	begin_test();
	do_write(PORT_DATA, 32'h0000_00C0, $urandom);	// Word the fetch will read
	val_a    = $urandom;
	val_c    = $urandom;
	seq_next = 0;
	foreach (ack_seq[i])
		ack_seq[i] = -1;
	fork
		master_access(PORT_DATA, 1'b1, 32'h0000_00C4, val_a, rd_data);
		master_access(PORT_FETCH, 1'b0, 32'h0000_00C0, '0, rd_fetch);
		master_access(PORT_AUX, 1'b1, 32'h0000_00C8, val_c, rd_aux);
	join
	check_value("data ack order", ack_seq[PORT_DATA], 0);
	check_value("fetch ack order", ack_seq[PORT_FETCH], 1);
	check_value("aux ack order", ack_seq[PORT_AUX], 2);
	check_value("o_fetch_rdata", rd_fetch, sb[word_of(32'h0000_00C0)]);
	read_check(PORT_DATA, 32'h0000_00C4);
	read_check(PORT_DATA, 32'h0000_00C8);
	end_test("priority");
endtask

task automatic test_back_pressure();
	logic [DATA_W-1:0] rd;
	begin_test();
	do_write(PORT_DATA, 32'h0000_0100, $urandom);
	do_write(PORT_AUX, 32'h0000_0104, $urandom);
	// Data master keeps req high after its ack
	raise_req(PORT_DATA, 1'b0, 32'h0000_0100, '0);
	wait_ack(PORT_DATA);
	check_value("o_data_rdata", data_rdata, sb[word_of(32'h0000_0100)]);
	master_access(PORT_FETCH, 1'b0, 32'h0000_0104, '0, rd);
	check_value("o_fetch_rdata", rd, sb[word_of(32'h0000_0104)]);
	check_value("o_data_ack", data_ack, 1'b1);
	check_value("o_data_rdata held", data_rdata, sb[word_of(32'h0000_0100)]);
	drop_req(PORT_DATA);
	wait_ack_low(PORT_DATA);
	check_value("o_data_ack", data_ack, 1'b0);
	end_test("back_pressure");
endtask

task automatic test_aliasing();
	logic [DATA_W-1:0] val;
	logic [DATA_W-1:0] rd;
	logic [ADDR_W-1:0] addr_lo;
	logic [ADDR_W-1:0] addr_hi;
	begin_test();
	addr_lo = 32'h0000_0154;
	addr_hi = addr_lo | 32'hABC0_0400;	// Same bits 9..2
	val = $urandom;
	do_write(PORT_DATA, addr_lo, val);
	master_access(PORT_AUX, 1'b0, addr_hi, '0, rd);
	check_value("o_aux_rdata alias", rd, val);
	val = $urandom;
	do_write(PORT_AUX, addr_hi, val);
	master_access(PORT_DATA, 1'b0, addr_lo, '0, rd);
	check_value("o_data_rdata alias", rd, val);
	read_check(PORT_FETCH, addr_hi);
	end_test("aliasing");
endtask

`endif

//--- tb_bus_access.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_access
	import bus_pkg::*;
();

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 4;
	localparam int ACK_POLL      = 64;	// Cycles a master waits for ack
	localparam int NUM_TESTS     = 6;
	localparam int TX_PER_TEST   = 8;	// Upper bound on transactions in one test
	localparam int TX_CYCLES     = 40;	// Worst case incl. contention and release
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_NS   =
		(RESET_CYCLES + NUM_TESTS * TX_PER_TEST * TX_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic              clock;
	logic              reset;

	logic              fetch_req;
	fetch_req_t        fetch;
	logic              fetch_ack;
	logic [DATA_W-1:0] fetch_rdata;

	logic              data_req;
	mem_req_t          data;
	logic              data_ack;
	logic [DATA_W-1:0] data_rdata;

	logic              aux_req;
	mem_req_t          aux;
	logic              aux_ack;
	logic [DATA_W-1:0] aux_rdata;

	// Mirror of every write by RAM word
	logic [DATA_W-1:0] sb [RAM_WORDS];

	int errors;
	int pass_count;
	int fail_count;
	int test_start_errors;
	int seq_next;
	int ack_seq [NUM_PORTS];

	bus_access_top dut0 (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_fetch_req   (fetch_req),
		.i_fetch       (fetch),
		.o_fetch_ack   (fetch_ack),
		.o_fetch_rdata (fetch_rdata),
		.i_data_req    (data_req),
		.i_data        (data),
		.o_data_ack    (data_ack),
		.o_data_rdata  (data_rdata),
		.i_aux_req     (aux_req),
		.i_aux         (aux),
		.o_aux_ack     (aux_ack),
		.o_aux_rdata   (aux_rdata)
	);

	`include "tb_bus_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(27575));
		reset      = 1'b1;
		fetch_req  = 1'b0;
		fetch      = '0;
		data_req   = 1'b0;
		data       = '0;
		aux_req    = 1'b0;
		aux        = '0;
		errors     = 0;
		pass_count = 0;
		fail_count = 0;
		seq_next   = 0;
		foreach (ack_seq[i])
			ack_seq[i] = -1;

		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		test_reset_state();
		test_data_aux_rw();
		test_fetch_shared();
		test_priority();
		test_back_pressure();
		test_aliasing();

		repeat (4) @(negedge clock);
		$display("Tests: %0d passed, %0d failed, %0d check errors",
			pass_count, fail_count, errors);
		if (errors == 0 && fail_count == 0) begin
			$display("Everything OK");
		end
		else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
bus_pkg.sv
bus_port.sv
bus_arbiter_ctrl.sv
bus_command_mux.sv
bus_ram.sv
bus_access_top.sv
tb_bus_access.sv

//--- Bender.yml
package:
  name: bus_access

sources:
  - bus_pkg.sv
  - bus_port.sv
  - bus_arbiter_ctrl.sv
  - bus_command_mux.sv
  - bus_ram.sv
  - bus_access_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_bus_access.sv
